// ==== flash_scramble_top.f ====
verilog/flash_scramble_pkg.sv
verilog/gf_mask_mult.sv
verilog/scramble_cipher.sv
verilog/flash_scramble.sv
verilog/xex_sequencer.sv
verilog/flash_scramble_top.sv
bench/flash_scramble_tb.sv

// ==== Makefile ====
TOP = flash_scramble_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f flash_scramble_top.f \
		--top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f flash_scramble_top.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Finished with no errors'

clean:
	rm -rf obj_dir

// ==== bench/flash_scramble_tb.sv ====
module flash_scramble_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumRows = 10;
  localparam int MaxWait = 40;
  localparam int ResetCycles = 4;
  // Each row runs at most three operations of about twelve cycles
  localparam int WatchdogCycles = ResetCycles + NumRows * 40;

  typedef enum logic [2:0] {
    ChkRoundTrip,
    ChkChanges,
    ChkAddrDep,
    ChkDisable,
    ChkBusy
  } check_e;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           req_i;
  flash_scramble_pkg::cipher_op_e op_type_i;
  flash_scramble_pkg::addr_t      addr_i;
  flash_scramble_pkg::data_t      data_i;
  logic                           disable_i;
  flash_scramble_pkg::key_t       addr_key_i, data_key_i;
  flash_scramble_pkg::key_t       rand_addr_key_i, rand_data_key_i;
  logic                           busy_o;
  logic                           done_o;
  flash_scramble_pkg::data_t      data_o;

  // Stimulus table with one entry per row in each array
  flash_scramble_pkg::cipher_op_e row_op   [NumRows];
  flash_scramble_pkg::addr_t      row_addr [NumRows];
  flash_scramble_pkg::data_t      row_word [NumRows];
  bit                             row_rand [NumRows];
  logic                           row_dis  [NumRows];
  check_e                         row_kind [NumRows];

  integer seed = 32;
  int error_count = 0;
  int accepted_count = 0;
  int done_count = 0;

  flash_scramble_top #(
    .SecScrambleEn(1'b1)
  ) flash_scramble_top_i (
    .clk_i,
    .rst_ni,
    .req_i,
    .op_type_i,
    .addr_i,
    .data_i,
    .disable_i,
    .addr_key_i,
    .data_key_i,
    .rand_addr_key_i,
    .rand_data_key_i,
    .busy_o,
    .done_o,
    .data_o
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // done_o is a full cycle wide, so one falling edge sees each pulse
  always @(negedge clk_i) begin
    if (rst_ni && done_o) begin
      done_count++;
    end
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_data(input string name, input flash_scramble_pkg::data_t got,
                            input flash_scramble_pkg::data_t exp);
    if (got !== exp) begin
      error_count++;
      fail_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      fail_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Advance to the drive point just after the next rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic define_row(input int idx, input flash_scramble_pkg::cipher_op_e op,
                            input flash_scramble_pkg::addr_t addr,
                            input flash_scramble_pkg::data_t word, input bit use_rand,
                            input logic dis, input check_e kind);
    row_op[idx]   = op;
    row_addr[idx] = addr;
    row_word[idx] = word;
    row_rand[idx] = use_rand;
    row_dis[idx]  = dis;
    row_kind[idx] = kind;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o && n < MaxWait) begin
      step();
      n++;
    end
    if (busy_o) begin
      fail_run("Timeout while waiting for busy_o to drop");
    end
  endtask

  task automatic wait_done(output flash_scramble_pkg::data_t res);
    bit found;
    found = 1'b0;
    res   = '0;
    for (int n = 0; n < MaxWait && !found; n++) begin
      step();
      if (done_o) begin
        found = 1'b1;
        res   = data_o;
      end
    end
    if (!found) begin
      fail_run("Timeout while waiting for done_o");
    end
  endtask

  // Pulse req_i for one cycle once the sequencer is idle
  task automatic start_op(input flash_scramble_pkg::cipher_op_e op,
                          input flash_scramble_pkg::addr_t addr,
                          input flash_scramble_pkg::data_t word, input logic dis);
    wait_idle();
    op_type_i = op;
    addr_i    = addr;
    data_i    = word;
    disable_i = dis;
    req_i     = 1'b1;
    accepted_count++;
    step();
    req_i = 1'b0;
  endtask

  task automatic run_op(input flash_scramble_pkg::cipher_op_e op,
                        input flash_scramble_pkg::addr_t addr,
                        input flash_scramble_pkg::data_t word, input logic dis,
                        output flash_scramble_pkg::data_t res);
    start_op(op, addr, word, dis);
    wait_done(res);
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    fail_run("Watchdog expired before all table rows completed");
  end

  initial begin
    flash_scramble_pkg::data_t      word, res_a, res_b;
    flash_scramble_pkg::key_t       saved_addr_key, saved_data_key;
    flash_scramble_pkg::cipher_op_e back_op;

    rst_ni          = 1'b0;
    req_i           = 1'b0;
    op_type_i       = flash_scramble_pkg::ScrambleOp;
    addr_i          = '0;
    data_i          = '0;
    disable_i       = 1'b0;
    addr_key_i      = 128'h3C4F_A1D2_9B07_E865_5A17_C3E9_0D42_B86F;
    data_key_i      = 128'h9E37_79B9_7F4A_7C15_F39C_C060_5CED_C834;
    rand_addr_key_i = 128'h6A09_E667_F3BC_C908_B2FB_1366_EA95_7D3E;
    rand_data_key_i = 128'hBB67_AE85_84CA_A73B_3C6E_F372_FE94_F82B;

    // Mixed directions, addresses at both ends and both key selections
    define_row(0, flash_scramble_pkg::ScrambleOp, 16'h0000, 64'h0123_4567_89AB_CDEF, 0, 0,
               ChkRoundTrip);
    define_row(1, flash_scramble_pkg::DeScrambleOp, 16'h1234, 64'hDEAD_BEEF_CAFE_F00D, 0, 0,
               ChkRoundTrip);
    define_row(2, flash_scramble_pkg::ScrambleOp, 16'hFFFF, '0, 1, 0, ChkRoundTrip);
    define_row(3, flash_scramble_pkg::ScrambleOp, 16'h0042, '0, 1, 1, ChkRoundTrip);
    define_row(4, flash_scramble_pkg::ScrambleOp, 16'h0007, 64'h0F1E_2D3C_4B5A_6978, 0, 0,
               ChkChanges);
    define_row(5, flash_scramble_pkg::ScrambleOp, 16'h8000, '0, 1, 1, ChkChanges);
    define_row(6, flash_scramble_pkg::ScrambleOp, 16'h0010, 64'h5555_5555_5555_5555, 0, 0,
               ChkAddrDep);
    define_row(7, flash_scramble_pkg::ScrambleOp, 16'h0ABC, '0, 1, 1, ChkAddrDep);
    define_row(8, flash_scramble_pkg::ScrambleOp, 16'h0321, 64'hFEDC_BA98_7654_3210, 0, 1,
               ChkDisable);
    define_row(9, flash_scramble_pkg::ScrambleOp, 16'h0100, '0, 1, 0, ChkBusy);

    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("done_o", done_o, 1'b0);

    for (int i = 0; i < NumRows; i++) begin
      if (row_rand[i]) begin
        word = {$random(seed), $random(seed)};
      end else begin
        word = row_word[i];
      end
      case (row_kind[i])
        ChkRoundTrip: begin
          // The opposite direction has to undo the first one exactly
          back_op = (row_op[i] == flash_scramble_pkg::ScrambleOp) ?
                    flash_scramble_pkg::DeScrambleOp : flash_scramble_pkg::ScrambleOp;
          run_op(row_op[i], row_addr[i], word, row_dis[i], res_a);
          run_op(back_op, row_addr[i], res_a, row_dis[i], res_b);
          check_data("data_o", res_b, word);
        end
        ChkChanges: begin
          run_op(row_op[i], row_addr[i], word, row_dis[i], res_a);
          check_bit("data_o differs from plain word", res_a != word, 1'b1);
        end
        ChkAddrDep: begin
          run_op(row_op[i], row_addr[i], word, row_dis[i], res_a);
          run_op(row_op[i], ~row_addr[i], word, row_dis[i], res_b);
          check_bit("data_o differs across addresses", res_a != res_b, 1'b1);
        end
        ChkDisable: begin
          // Random keys go in through disable_i first and then as the normal keys
          run_op(row_op[i], row_addr[i], word, 1'b1, res_a);
          saved_addr_key = addr_key_i;
          saved_data_key = data_key_i;
          addr_key_i     = rand_addr_key_i;
          data_key_i     = rand_data_key_i;
          run_op(row_op[i], row_addr[i], word, 1'b0, res_b);
          addr_key_i = saved_addr_key;
          data_key_i = saved_data_key;
          check_data("data_o", res_a, res_b);
        end
        default: begin
          start_op(row_op[i], row_addr[i], word, row_dis[i]);
          step();
          check_bit("busy_o", busy_o, 1'b1);
          // A request while busy must be dropped without touching the payload
          addr_i = ~row_addr[i];
          data_i = ~word;
          req_i  = 1'b1;
          step();
          req_i = 1'b0;
          wait_done(res_a);
          run_op(row_op[i], row_addr[i], word, row_dis[i], res_b);
          check_data("data_o", res_a, res_b);
          step();
          step();
          check_bit("done_o count equals accepted requests",
                    done_count == accepted_count, 1'b1);
        end
      endcase
    end

    step();
    if (error_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "Checks failed");
    end
  end

endmodule

// ==== verilog/flash_scramble_top.sv ====
module flash_scramble_top #(
  parameter bit SecScrambleEn = 1'b1
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  flash_scramble_pkg::cipher_op_e op_type_i,
  input  flash_scramble_pkg::addr_t      addr_i,
  input  flash_scramble_pkg::data_t      data_i,
  input  logic                           disable_i,
  input  flash_scramble_pkg::key_t       addr_key_i,
  input  flash_scramble_pkg::key_t       data_key_i,
  input  flash_scramble_pkg::key_t       rand_addr_key_i,
  input  flash_scramble_pkg::key_t       rand_data_key_i,
  output logic                           busy_o,
  output logic                           done_o,
  output flash_scramble_pkg::data_t      data_o
);

  // Handshake and payload between the sequencer and the scrambler
  logic                           calc_req, calc_ack;
  logic                           op_req, op_ack;
  flash_scramble_pkg::cipher_op_e op_type;
  flash_scramble_pkg::addr_t      addr;
  flash_scramble_pkg::data_t      whitened, mask, cipher;

  xex_sequencer u_seq (
    .clk_i,
    .rst_ni,
    .req_i,
    .op_type_i,
    .addr_i,
    .data_i,
    .calc_ack_i(calc_ack),
    .op_ack_i  (op_ack),
    .mask_i    (mask),
    .cipher_i  (cipher),
    .busy_o,
    .calc_req_o(calc_req),
    .op_req_o  (op_req),
    .op_type_o (op_type),
    .addr_o    (addr),
    .whitened_o(whitened),
    .done_o,
    .data_o
  );

  flash_scramble #(
    .SecScrambleEn(SecScrambleEn)
  ) u_scramble (
    .clk_i,
    .rst_ni,
    .disable_i,
    .calc_req_i(calc_req),
    .op_req_i  (op_req),
    .op_type_i (op_type),
    .addr_i    (addr),
    .whitened_i(whitened),
    .addr_key_i,
    .data_key_i,
    .rand_addr_key_i,
    .rand_data_key_i,
    .calc_ack_o(calc_ack),
    .op_ack_o  (op_ack),
    .mask_o    (mask),
    .cipher_o  (cipher)
  );

endmodule

// ==== verilog/xex_sequencer.sv ====
module xex_sequencer (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  flash_scramble_pkg::cipher_op_e op_type_i,
  input  flash_scramble_pkg::addr_t      addr_i,
  input  flash_scramble_pkg::data_t      data_i,
  input  logic                           calc_ack_i,
  input  logic                           op_ack_i,
  input  flash_scramble_pkg::data_t      mask_i,
  input  flash_scramble_pkg::data_t      cipher_i,
  output logic                           busy_o,
  output logic                           calc_req_o,
  output logic                           op_req_o,
  output flash_scramble_pkg::cipher_op_e op_type_o,
  output flash_scramble_pkg::addr_t      addr_o,
  output flash_scramble_pkg::data_t      whitened_o,
  output logic                           done_o,
  output flash_scramble_pkg::data_t      data_o
);

  typedef enum logic [1:0] {
    StIdle,
    StMask,
    StCipher,
    StDone
  } state_e;

  state_e state_q;

  // Request payload, the mask and the final result
  flash_scramble_pkg::cipher_op_e op_q;
  flash_scramble_pkg::addr_t      addr_q;
  flash_scramble_pkg::data_t      data_q;
  flash_scramble_pkg::data_t      mask_q;
  flash_scramble_pkg::data_t      result_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
    end else begin
      case (state_q)
        StIdle: begin
          if (req_i) begin
            state_q <= StMask;
          end
        end
        StMask: begin
          if (calc_ack_i) begin
            state_q <= StCipher;
          end
        end
        StCipher: begin
          if (op_ack_i) begin
            state_q <= StDone;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Payload is captured on acceptance and on each ack
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && req_i) begin
      op_q   <= op_type_i;
      addr_q <= addr_i;
      data_q <= data_i;
    end
    if (state_q == StMask && calc_ack_i) begin
      mask_q <= mask_i;
    end
    // Second whitening with the same mask
    if (state_q == StCipher && op_ack_i) begin
      result_q <= cipher_i ^ mask_q;
    end
  end

  // Requests are plain levels decoded from the state and drop after the ack
  assign calc_req_o = (state_q == StMask);
  assign op_req_o   = (state_q == StCipher);
  assign busy_o     = (state_q != StIdle);
  assign done_o     = (state_q == StDone);

  assign op_type_o  = op_q;
  assign addr_o     = addr_q;
  // First whitening stays steady for the whole cipher request
  assign whitened_o = data_q ^ mask_q;
  assign data_o     = result_q;

  // The mask and cipher stages never overlap
  a_req_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(calc_req_o && op_req_o));

endmodule

// ==== verilog/flash_scramble.sv ====
module flash_scramble #(
  parameter bit SecScrambleEn = 1'b1
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           disable_i,
  input  logic                           calc_req_i,
  input  logic                           op_req_i,
  input  flash_scramble_pkg::cipher_op_e op_type_i,
  input  flash_scramble_pkg::addr_t      addr_i,
  input  flash_scramble_pkg::data_t      whitened_i,
  input  flash_scramble_pkg::key_t       addr_key_i,
  input  flash_scramble_pkg::key_t       data_key_i,
  input  flash_scramble_pkg::key_t       rand_addr_key_i,
  input  flash_scramble_pkg::key_t       rand_data_key_i,
  output logic                           calc_ack_o,
  output logic                           op_ack_o,
  output flash_scramble_pkg::data_t      mask_o,
  output flash_scramble_pkg::data_t      cipher_o
);

  // The address key choice may only move between mask calculations
  logic addr_key_sel;
  flash_scramble_pkg::key_t muxed_addr_key;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_key_sel <= 1'b0;
    end else if (!calc_req_i || calc_ack_o) begin
      addr_key_sel <= disable_i;
    end
  end

  assign muxed_addr_key = addr_key_sel ? rand_addr_key_i : addr_key_i;

  if (SecScrambleEn) begin : gen_gf_mult
    // Upper key bits pad the bank address to a full field element
    gf_mask_mult u_mult (
      .clk_i,
      .rst_ni,
      .req_i      (calc_req_i),
      .operand_a_i({muxed_addr_key[flash_scramble_pkg::DataWidth +:
                                   (flash_scramble_pkg::DataWidth -
                                    flash_scramble_pkg::BankAddrW)], addr_i}),
      .operand_b_i(muxed_addr_key[flash_scramble_pkg::DataWidth-1:0]),
      .ack_o      (calc_ack_o),
      .prod_o     (mask_o)
    );
  end else begin : gen_no_gf_mult
    assign mask_o = '0;

    // Answer each mask request after one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        calc_ack_o <= 1'b0;
      end else begin
        calc_ack_o <= calc_req_i && !calc_ack_o;
      end
    end
  end

  // Same locking rule for the data key, tied to the op handshake
  logic data_key_sel;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_key_sel <= 1'b0;
    end else if (!op_req_i || op_ack_o) begin
      data_key_sel <= disable_i;
    end
  end

  logic dec;
  assign dec = (op_type_i == flash_scramble_pkg::DeScrambleOp);

  // A held op_req keeps launching words into the cipher, so the ack needs
  // both the launch flag and the cipher's valid to avoid a stale second hit
  logic cipher_valid_in_d, cipher_valid_in_q;
  logic cipher_valid_out;

  assign cipher_valid_in_d = op_ack_o ? 1'b0 : op_req_i & !cipher_valid_out;
  assign op_ack_o          = cipher_valid_in_q & cipher_valid_out;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cipher_valid_in_q <= 1'b0;
    end else begin
      cipher_valid_in_q <= cipher_valid_in_d;
    end
  end

  if (SecScrambleEn) begin : gen_cipher
    scramble_cipher u_cipher (
      .clk_i,
      .rst_ni,
      .valid_i(cipher_valid_in_d),
      .dec_i  (dec),
      .data_i (whitened_i),
      .key_i  (data_key_sel ? rand_data_key_i : data_key_i),
      .valid_o(cipher_valid_out),
      .data_o (cipher_o)
    );
  end else begin : gen_no_cipher
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cipher_valid_out <= 1'b0;
      end else begin
        cipher_valid_out <= cipher_valid_in_d;
      end
    end

    assign cipher_o = whitened_i;
  end

  // The direction feeds both cipher halves and must not flip mid operation
  a_op_type_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    op_req_i && $past(op_req_i) |-> $stable(op_type_i));

endmodule

// ==== verilog/scramble_cipher.sv ====
module scramble_cipher (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      valid_i,
  input  logic                      dec_i,
  input  flash_scramble_pkg::data_t data_i,
  input  flash_scramble_pkg::key_t  key_i,
  output logic                      valid_o,
  output flash_scramble_pkg::data_t data_o
);

  // Rounds below CipherRounds use the low key half, the rest the high half
  function automatic flash_scramble_pkg::data_t round_key(flash_scramble_pkg::key_t key,
                                                         int unsigned r);
    flash_scramble_pkg::data_t half;
    if (r < flash_scramble_pkg::CipherRounds) begin
      half = key[flash_scramble_pkg::DataWidth-1:0];
    end else begin
      half = key[flash_scramble_pkg::KeySize-1 -: flash_scramble_pkg::DataWidth];
    end
    return half ^ flash_scramble_pkg::RoundConst[r];
  endfunction

  function automatic flash_scramble_pkg::data_t sub_nibbles(flash_scramble_pkg::data_t x,
                                                           logic inv);
    flash_scramble_pkg::data_t y;
    for (int i = 0; i < flash_scramble_pkg::DataWidth / 4; i++) begin
      if (inv) begin
        y[4*i +: 4] = flash_scramble_pkg::SBoxInv[x[4*i +: 4]];
      end else begin
        y[4*i +: 4] = flash_scramble_pkg::SBox[x[4*i +: 4]];
      end
    end
    return y;
  endfunction

  // Key addition, substitution, then a one nibble rotate to the left
  function automatic flash_scramble_pkg::data_t round_fwd(flash_scramble_pkg::data_t x,
                                                         flash_scramble_pkg::data_t rk);
    flash_scramble_pkg::data_t s;
    s = sub_nibbles(x ^ rk, 1'b0);
    return {s[flash_scramble_pkg::DataWidth-5:0], s[flash_scramble_pkg::DataWidth-1 -: 4]};
  endfunction

  // Undo the steps of round_fwd in the opposite order
  function automatic flash_scramble_pkg::data_t round_inv(flash_scramble_pkg::data_t x,
                                                         flash_scramble_pkg::data_t rk);
    flash_scramble_pkg::data_t s;
    s = {x[3:0], x[flash_scramble_pkg::DataWidth-1:4]};
    return sub_nibbles(s, 1'b1) ^ rk;
  endfunction

  flash_scramble_pkg::data_t mid_d, mid_q, out_d;
  logic valid_mid_q, dec_mid_q;

  // First half runs rounds 0..2 forward or rounds 5..3 inverted
  always_comb begin
    mid_d = data_i;
    for (int i = 0; i < flash_scramble_pkg::CipherRounds; i++) begin
      if (dec_i) begin
        mid_d = round_inv(mid_d,
                          round_key(key_i, 2 * flash_scramble_pkg::CipherRounds - 1 - i));
      end else begin
        mid_d = round_fwd(mid_d, round_key(key_i, i));
      end
    end
  end

  // Second half takes the remaining rounds, the key is held by the caller
  always_comb begin
    out_d = mid_q;
    for (int i = 0; i < flash_scramble_pkg::CipherRounds; i++) begin
      if (dec_mid_q) begin
        out_d = round_inv(out_d, round_key(key_i, flash_scramble_pkg::CipherRounds - 1 - i));
      end else begin
        out_d = round_fwd(out_d, round_key(key_i, flash_scramble_pkg::CipherRounds + i));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_mid_q <= 1'b0;
      dec_mid_q   <= 1'b0;
      valid_o     <= 1'b0;
    end else begin
      valid_mid_q <= valid_i;
      dec_mid_q   <= dec_i;
      valid_o     <= valid_mid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    mid_q  <= mid_d;
    data_o <= out_d;
  end

  // Two register stages, so the result appears exactly two cycles later
  a_valid_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> ##2 valid_o);
  a_valid_origin: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> $past(valid_i, 2));

endmodule

// ==== verilog/gf_mask_mult.sv ====
module gf_mask_mult (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  flash_scramble_pkg::data_t operand_a_i,
  input  flash_scramble_pkg::data_t operand_b_i,
  output logic                      ack_o,
  output flash_scramble_pkg::data_t prod_o
);

  // Multiply by x and reduce modulo the field polynomial
  function automatic flash_scramble_pkg::data_t mul_x(flash_scramble_pkg::data_t v);
    flash_scramble_pkg::data_t r;
    r = {v[flash_scramble_pkg::DataWidth-2:0], 1'b0};
    if (v[flash_scramble_pkg::DataWidth-1]) begin
      r = r ^ flash_scramble_pkg::ScrambleIPoly;
    end
    return r;
  endfunction

  // Index of the slice of operand b being folded in this cycle
  logic [$clog2(flash_scramble_pkg::GfMultCycles)-1:0] cnt_q;
  logic ack_q;

  // Running product and operand a scaled by x to the current bit position
  flash_scramble_pkg::data_t acc_q, acc_d;
  flash_scramble_pkg::data_t shift_q, shift_d;

  // A new product starts from a clean accumulator on slice 0
  always_comb begin
    acc_d   = (cnt_q == '0) ? '0 : acc_q;
    shift_d = (cnt_q == '0) ? operand_a_i : shift_q;
    for (int j = 0; j < flash_scramble_pkg::DataWidth / flash_scramble_pkg::GfMultCycles;
         j++) begin
      if (operand_b_i[int'(cnt_q) * (flash_scramble_pkg::DataWidth /
                      flash_scramble_pkg::GfMultCycles) + j]) begin
        acc_d = acc_d ^ shift_d;
      end
      shift_d = mul_x(shift_d);
    end
  end

  // The ack cycle doubles as the idle cycle, nothing is folded in then
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      if (req_i && !ack_q) begin
        if (int'(cnt_q) == flash_scramble_pkg::GfMultCycles - 1) begin
          cnt_q <= '0;
          ack_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !ack_q) begin
      acc_q   <= acc_d;
      shift_q <= shift_d;
    end
  end

  assign ack_o  = ack_q;
  assign prod_o = acc_q;

  // Operand b is read slice by slice, so both operands must hold mid product
  a_operands_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && cnt_q != '0 |-> $stable(operand_a_i) && $stable(operand_b_i));

endmodule

// ==== verilog/flash_scramble_pkg.sv ====
package flash_scramble_pkg;

  // Word and address widths of one flash bank
  localparam int DataWidth = 64;
  localparam int BankAddrW = 16;
  localparam int KeySize   = 128;

  // The mask multiplier folds in a quarter of operand b per cycle
  localparam int GfMultCycles = 4;

  // Low 64 bits of x^64 + x^4 + x^3 + x + 1, the leading term is implied
  localparam logic [DataWidth-1:0] ScrambleIPoly = 64'h0000_0000_0000_001B;

  // Rounds on each side of the cipher's halfway register
  localparam int CipherRounds = 3;

  // One constant per round, index 0 in the lowest word
  localparam logic [2*CipherRounds-1:0][DataWidth-1:0] RoundConst = {
    64'h7EF8_4F78_FD95_5CB1,
    64'hBE54_66CF_34E9_0C6C,
    64'h4528_21E6_38D0_1377,
    64'h082E_FA98_EC4E_6C89,
    64'hA409_3822_299F_31D0,
    64'h1319_8A2E_0370_7344
  };

  // PRINCE S-box, entry 0 sits in the lowest nibble
  localparam logic [15:0][3:0] SBox    = 64'h4D5E_0876_19CA_23FB;
  localparam logic [15:0][3:0] SBoxInv = 64'h1CE5_046A_98DF_237B;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BankAddrW-1:0] addr_t;
  typedef logic [KeySize-1:0]   key_t;

  typedef enum logic {
    ScrambleOp   = 1'b0,
    DeScrambleOp = 1'b1
  } cipher_op_e;

endpackage
